//--- hw/axisSpeed.sv
`timescale 1ns/1ns

module axisSpeed import encoderPkg::*; #(
	parameter axisMaskT DirInvert = '0 // mirrored wheels count the other way
) (
	input  logic      CLOCK_50,
	input  logic      reset,
	sensorEdgeIf.sink edges,
	input  logic      windowEnd,
	output speedT     speed [NumAxes],
	output axisMaskT  direction
);

	edgeCountT countA [NumAxes];
	edgeCountT countB [NumAxes];

	// average of both channels, remainder dropped
	function automatic speedT halfSum(input edgeCountT a, input edgeCountT b);
		logic [$bits(edgeCountT):0] total;
		total = a + b;
		return speedT'(total >> 1);
	endfunction

	// ========================================
	// edge counters
	// ========================================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NumAxes; i++) begin
				countA[i] <= '0;
				countB[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NumAxes; i++) begin
				if (windowEnd) begin
					// an edge in the last cycle belongs to the new window
					countA[i] <= edgeCountT'(edges.axisARise[i]);
					countB[i] <= edgeCountT'(edges.axisBRise[i]);
				end else begin
					countA[i] <= countA[i] + edgeCountT'(edges.axisARise[i]);
					countB[i] <= countB[i] + edgeCountT'(edges.axisBRise[i]);
				end
			end
		end
	end

	// ========================================
	// speed latch and direction
	// ========================================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NumAxes; i++) begin
				speed[i] <= '0;
			end
		end else if (windowEnd) begin
			for (int i = 0; i < NumAxes; i++) begin
				speed[i] <= halfSum(countA[i], countB[i]);
			end
		end
	end

	// B level seen on an A rise gives the rotation sense
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			direction <= '0;
		end else begin
			for (int i = 0; i < NumAxes; i++) begin
				if (edges.axisARise[i]) begin
					direction[i] <= edges.axisBLevel[i] ^ DirInvert[i];
				end
			end
		end
	end

endmodule

//--- hw/beamCapture.sv
`timescale 1ns/1ns

module beamCapture import turretPkg::*; (
	input  logic      CLOCK_50,
	input  logic      reset,
	sensorEdgeIf.sink edges,
	input  logic      markStart,
	input  logic      markEnd,
	input  logic      commit,
	output angleT     beamStart,
	output angleT     beamEnd,
	output logic      beamValid,
	output logic      newTurn
);

	angleT angle;        // ticks since last sync
	angleT pendingStart;
	angleT pendingEnd;

	// turret angle and turn toggle
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			angle   <= '0;
			newTurn <= 1'b0;
		end else if (edges.turretSync) begin
			angle   <= '0; // sync wins over a tick in the same cycle
			newTurn <= ~newTurn;
		end else if (edges.turretTick) begin
			angle <= angle + 1'b1;
		end
	end

	// beam edges seen so far, not yet confirmed
	always_ff @(posedge CLOCK_50) begin
		if (markStart) begin
			pendingStart <= angle;
		end
		if (markEnd) begin
			pendingEnd <= angle;
		end
	end

	// publish a finished beam
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			beamStart <= '0;
			beamEnd   <= '0;
			beamValid <= 1'b0;
		end else begin
			beamValid <= commit; // one clock after commit
			if (commit) begin
				beamStart <= pendingStart;
				beamEnd   <= pendingEnd;
			end
		end
	end

endmodule

//--- hw/beamFilter.sv
`timescale 1ns/1ns

module beamFilter import turretPkg::*; #(
	parameter int GapTicks = 20 // ticks of dropout that really end a beam
) (
	input  logic      CLOCK_50,
	input  logic      reset,
	sensorEdgeIf.sink edges,
	output logic      markStart,
	output logic      markEnd,
	output logic      commit
);

	beamStateT state;
	beamStateT nextState;
	gapCountT  gapCount;
	logic      gapDone;

	// last tick of a dropout long enough to count
	assign gapDone = edges.turretTick && (gapCount == gapCountT'(GapTicks - 1));

	// ========================================
	// beam FSM
	// ========================================
	always_comb begin
		nextState = state;
		markStart = 1'b0;
		markEnd   = 1'b0;
		commit    = 1'b0;
		case (state)
			Idle: begin
				if (edges.beamSign) begin
					markStart = 1'b1;
					nextState = Receive;
				end
			end
			Receive: begin
				if (!edges.beamSign) begin
					markEnd   = 1'b1; // may be replaced if this is a glitch
					nextState = Gap;
				end
			end
			Gap: begin
				if (edges.beamSign) begin
					nextState = Receive; // glitch, bridge it
				end else if (gapDone) begin
					commit    = 1'b1;
					nextState = Idle;
				end
			end
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	// turret ticks while the laser is gone
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			gapCount <= '0;
		end else if (markEnd) begin
			gapCount <= '0;
		end else if (state == Gap && edges.turretTick && !edges.beamSign) begin
			gapCount <= gapCount + 1'b1;
		end
	end

endmodule

//--- hw/encoderPkg.sv
// ========================================
// wheel encoder types
// ========================================
package encoderPkg;

	// propulsion left, propulsion right, odometry left, odometry right
	localparam int NumAxes = 4;

	// rising edges of one channel within one window
	typedef logic [15:0] edgeCountT;

	// (A + B) / 2 over one window
	typedef logic [15:0] speedT;

	typedef logic [NumAxes-1:0] axisMaskT; // one bit per axis, same order as above

endpackage

//--- hw/inputSync.sv
`timescale 1ns/1ns

module inputSync import encoderPkg::*; (
	input  logic        CLOCK_50,
	input  logic        reset,
	input  axisMaskT    encA,
	input  axisMaskT    encB,
	input  logic        turretEncA,
	input  logic        laserSync,
	input  logic        laserSign,
	sensorEdgeIf.source edges
);

	// all raw lines handled as one vector
	localparam int NumLines = 2 * NumAxes + 3;

	logic [NumLines-1:0] rawIn;
	logic [NumLines-1:0] meta;    // first stage, may go metastable
	logic [NumLines-1:0] stable;  // second stage
	logic [NumLines-1:0] delayed; // previous stable value
	logic [NumLines-1:0] rise;

	assign rawIn = {laserSign, laserSync, turretEncA, encB, encA};

	// two flops, then a registered edge detect
	// so a pulse and its level both show 3 clocks after the pin
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			meta    <= '0;
			stable  <= '0;
			delayed <= '0;
			rise    <= '0;
		end else begin
			meta    <= rawIn;
			stable  <= meta;
			delayed <= stable;
			rise    <= stable & ~delayed;
		end
	end

	// split back out by line
	assign edges.axisARise  = rise[NumAxes-1:0];
	assign edges.axisBRise  = rise[2*NumAxes-1:NumAxes];
	assign edges.axisBLevel = delayed[2*NumAxes-1:NumAxes];
	assign edges.turretTick = rise[2*NumAxes];
	assign edges.turretSync = rise[2*NumAxes+1];
	assign edges.beamSign   = delayed[2*NumAxes+2]; // level, not edge

endmodule

//--- hw/robotSensorTop.sv
`timescale 1ns/1ns

module robotSensorTop import encoderPkg::*, turretPkg::*; #(
	parameter int       WindowCycles = 500000,
	parameter int       GapTicks     = 20,
	parameter axisMaskT DirInvert    = 4'b0110 // right wheel and left odometry mirrored
) (
	input  logic     CLOCK_50,
	input  logic     reset,
	input  axisMaskT encA,
	input  axisMaskT encB,
	input  logic     turretEncA,
	input  logic     laserSync,
	input  logic     laserSign,
	output speedT    speed [NumAxes],
	output axisMaskT direction,
	output angleT    beamStart,
	output angleT    beamEnd,
	output logic     beamValid,
	output logic     newTurn
);

	sensorEdgeIf edges ();

	logic windowEnd;
	logic markStart;
	logic markEnd;
	logic commit;

	inputSync inputSync_inst (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.encA       (encA),
		.encB       (encB),
		.turretEncA (turretEncA),
		.laserSync  (laserSync),
		.laserSign  (laserSign),
		.edges      (edges.source)
	);

	// ========================================
	// wheel speed
	// ========================================
	windowTimer #(.WindowCycles(WindowCycles)) windowTimer_inst (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.windowEnd (windowEnd)
	);

	axisSpeed #(.DirInvert(DirInvert)) axisSpeed_inst (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.edges     (edges.sink),
		.windowEnd (windowEnd),
		.speed     (speed),
		.direction (direction)
	);

	// ========================================
	// laser turret
	// ========================================
	beamFilter #(.GapTicks(GapTicks)) beamFilter_inst (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.edges     (edges.sink),
		.markStart (markStart),
		.markEnd   (markEnd),
		.commit    (commit)
	);

	beamCapture beamCapture_inst (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.edges     (edges.sink),
		.markStart (markStart),
		.markEnd   (markEnd),
		.commit    (commit),
		.beamStart (beamStart),
		.beamEnd   (beamEnd),
		.beamValid (beamValid),
		.newTurn   (newTurn)
	);

endmodule

//--- hw/sensorEdgeIf.sv
`timescale 1ns/1ns

// sensor lines after synchronization, as pulses and levels on CLOCK_50
interface sensorEdgeIf import encoderPkg::*; ();

	axisMaskT axisARise;  // channel A rise, one clock
	axisMaskT axisBRise;  // channel B rise, one clock
	axisMaskT axisBLevel; // channel B level, aligned with the pulses
	logic     turretTick; // turret encoder A rise
	logic     turretSync; // once per turret turn
	logic     beamSign;   // laser receive level

	modport source (
		output axisARise,
		output axisBRise,
		output axisBLevel,
		output turretTick,
		output turretSync,
		output beamSign
	);

	modport sink (
		input axisARise,
		input axisBRise,
		input axisBLevel,
		input turretTick,
		input turretSync,
		input beamSign
	);

endinterface

//--- hw/turretPkg.sv
// ========================================
// laser turret types
// ========================================
package turretPkg;

	// turret ticks counted since the last sync pulse
	typedef logic [15:0] angleT;

	// beam filter states
	typedef enum logic [1:0] {
		Idle,    // no beam seen
		Receive, // laser on the receiver
		Gap      // dropout, may still be a glitch
	} beamStateT;

	typedef logic [5:0] gapCountT; // turret ticks spent in Gap

endpackage

//--- hw/windowTimer.sv
`timescale 1ns/1ns

module windowTimer #(
	parameter int WindowCycles = 500000 // 10 ms at 50 MHz
) (
	input  logic CLOCK_50,
	input  logic reset,
	output logic windowEnd
);

	localparam int CountWidth = (WindowCycles > 1) ? $clog2(WindowCycles) : 1;
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(WindowCycles - 1);

	logic [CountWidth-1:0] cycleCount;

	// high during the last count of every window
	assign windowEnd = (cycleCount == LastCount);

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			cycleCount <= '0;
		end else if (windowEnd) begin
			cycleCount <= '0; // wrap, next window starts
		end else begin
			cycleCount <= cycleCount + 1'b1;
		end
	end

endmodule

//--- robotSensor.f
hw/encoderPkg.sv
hw/turretPkg.sv
hw/sensorEdgeIf.sv
hw/inputSync.sv
hw/windowTimer.sv
hw/axisSpeed.sv
hw/beamFilter.sv
hw/beamCapture.sv
hw/robotSensorTop.sv
testbench/robotSensorTb.sv

//--- testbench/robotSensorStim.txt
# kind 0 reset check, 1 speed window, 2 turret beam; all columns decimal
# speed:  1 axis aPulses bPulses bLevel 0 0 expSpeed expDir 0 0
# turret: 2 sync n m gap k drop expStart expEnd expNewTurn expValidPulses
0 0 0 0 0 0 0 0 0 0 0
# one axis per window, B level held over the A pulses when bLevel is 1
1 0 5 5 1 0 0 5 1 0 0
1 1 4 3 1 0 0 3 0 0 0
1 2 6 5 0 0 0 5 1 0 0
1 3 3 2 0 0 0 2 0 0 0
1 0 7 4 0 0 0 5 0 0 0
1 1 1 0 0 0 0 0 1 0 0
# no A rise, so direction keeps its last value
1 3 0 9 1 0 0 4 0 0 0
1 2 12 0 0 0 0 6 1 0 0
# plain beam, dropout longer than the gap limit
2 1 5 7 0 0 5 5 12 1 1
# short dropout bridged, end taken at the second drop
2 1 3 6 2 4 6 3 15 0 1
# no sync, angle keeps counting from the last step
2 0 4 2 0 0 5 25 27 0 1
# longest dropout that still counts as a glitch
2 1 10 3 3 1 5 10 17 1 1
# beam right after sync, dropout exactly at the limit
2 1 0 4 0 0 4 0 4 0 1

//--- testbench/robotSensorTb.sv
`timescale 1ns/1ns

module robotSensorTb import encoderPkg::*, turretPkg::*; ();

	localparam int WindowCycles = 64;
	localparam int GapTicks     = 4;
	localparam int ValidTimeout = 200; // clocks to wait for beamValid
	localparam int LineTurret   = 2 * NumAxes;
	localparam int LineSync     = LineTurret + 1;
	localparam int LineSign     = LineTurret + 2;

	logic     CLOCK_50;
	logic     reset;
	axisMaskT encA;
	axisMaskT encB;
	logic     turretEncA;
	logic     laserSync;
	logic     laserSign;
	speedT    speed [NumAxes];
	axisMaskT direction;
	angleT    beamStart;
	angleT    beamEnd;
	logic     beamValid;
	logic     newTurn;

	int sinceReset; // clocks since reset release, gives the window phase
	int validCount; // beamValid pulses seen in the current step
	int testsRun;
	int testsFailed;
	bit stepFailed;

	robotSensorTop #(
		.WindowCycles (WindowCycles),
		.GapTicks     (GapTicks)
	) robotSensorTop_inst (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.encA       (encA),
		.encB       (encB),
		.turretEncA (turretEncA),
		.laserSync  (laserSync),
		.laserSign  (laserSign),
		.speed      (speed),
		.direction  (direction),
		.beamStart  (beamStart),
		.beamEnd    (beamEnd),
		.beamValid  (beamValid),
		.newTurn    (newTurn)
	);

	initial CLOCK_50 = 1'b0;
	always #10 CLOCK_50 = ~CLOCK_50;

	// ========================================
	// clocking and pin drive
	// ========================================
	task tick();
		@(negedge CLOCK_50);
		if (beamValid) begin
			validCount++; // sampled mid cycle
		end
		@(posedge CLOCK_50);
		sinceReset++;
	endtask

	task setLine(input int line, input logic value);
		if (line < NumAxes) begin
			encA[line] <= value;
		end else if (line < LineTurret) begin
			encB[line - NumAxes] <= value;
		end else if (line == LineTurret) begin
			turretEncA <= value;
		end else if (line == LineSync) begin
			laserSync <= value;
		end else begin
			laserSign <= value;
		end
	endtask

	// two clocks high, two low
	task pulseLine(input int line);
		setLine(line, 1'b1);
		tick();
		tick();
		setLine(line, 1'b0);
		tick();
		tick();
	endtask

	task waitPhase(input int phase);
		int guard;
		guard = 0;
		while ((sinceReset % WindowCycles) != phase && guard < WindowCycles + 2) begin
			tick();
			guard++;
		end
		if ((sinceReset % WindowCycles) != phase) begin
			$display("timeout while waiting for window phase %0d", phase);
			stepFailed = 1'b1;
		end
	endtask

	task compare(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			stepFailed = 1'b1;
		end
	endtask

	// ========================================
	// test steps
	// ========================================
	task checkReset();
		for (int i = 0; i < NumAxes; i++) begin
			compare($sformatf("speed[%0d]", i), speed[i], 0);
		end
		compare("direction", direction, 0);
		compare("beamStart", beamStart, 0);
		compare("beamEnd", beamEnd, 0);
		compare("beamValid", beamValid, 0);
		compare("newTurn", newTurn, 0);
	endtask

	task runSpeed(input int axis, input int aCount, input int bCount, input int bLevel,
			input int expSpeed, input int expDir);
		int plainB;
		plainB = (bLevel != 0) ? bCount - 1 : bCount; // last B rise held as a level
		waitPhase(3); // well clear of both window ends
		repeat (plainB) pulseLine(NumAxes + axis);
		if (bLevel != 0) begin
			setLine(NumAxes + axis, 1'b1);
			tick();
			tick();
		end
		repeat (aCount) pulseLine(axis);
		if (bLevel != 0) begin
			setLine(NumAxes + axis, 1'b0);
			tick();
		end
		waitPhase(2); // speed latched at phase 0
		compare($sformatf("speed[%0d]", axis), speed[axis], expSpeed);
		compare($sformatf("direction[%0d]", axis), direction[axis], expDir);
	endtask

	task runTurret(input int sync, input int n, input int m, input int gap, input int k,
			input int drop, input int expStart, input int expEnd, input int expTurn,
			input int expValid);
		int guard;
		validCount = 0;
		if (sync != 0) begin
			pulseLine(LineSync);
		end
		repeat (n) pulseLine(LineTurret);
		setLine(LineSign, 1'b1);
		tick();
		tick();
		repeat (m) pulseLine(LineTurret);
		setLine(LineSign, 1'b0);
		tick();
		tick();
		if (gap > 0) begin
			repeat (gap) pulseLine(LineTurret); // short dropout
			setLine(LineSign, 1'b1);
			tick();
			tick();
			repeat (k) pulseLine(LineTurret);
			setLine(LineSign, 1'b0);
			tick();
			tick();
		end
		repeat (drop) pulseLine(LineTurret);
		guard = 0;
		while (validCount == 0 && guard < ValidTimeout) begin
			tick();
			guard++;
		end
		if (validCount == 0) begin
			$display("timeout while waiting for beamValid");
			stepFailed = 1'b1;
		end
		repeat (4) tick(); // room for a stray second pulse
		compare("beamValid pulses", validCount, expValid);
		compare("beamStart", beamStart, expStart);
		compare("beamEnd", beamEnd, expEnd);
		compare("newTurn", newTurn, expTurn);
	endtask

	function string stepName(input int kind);
		case (kind)
			0: return "reset state";
			1: return "wheel speed";
			2: return "turret beam";
			default: return "unknown";
		endcase
	endfunction

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int    fd;
		int    code;
		int    fields;
		int    kind;
		int    col [10];
		string line;
		reset       = 1'b1;
		encA        = '0;
		encB        = '0;
		turretEncA  = 1'b0;
		laserSync   = 1'b0;
		laserSign   = 1'b0;
		sinceReset  = 0;
		validCount  = 0;
		testsRun    = 0;
		testsFailed = 0;
		repeat (2) @(posedge CLOCK_50);
		reset <= 1'b0;
		sinceReset = 0; // the window timer starts counting from here
		fd = $fopen("testbench/robotSensorStim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			testsFailed++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code != 0 && line.len() > 1 && line[0] != "#") begin
					fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", kind,
						col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
						col[8], col[9]);
					stepFailed = 1'b0;
					testsRun++;
					if (fields != 11) begin
						$display("stimulus line for test %0d is malformed", testsRun);
						stepFailed = 1'b1;
					end else if (kind == 0) begin
						checkReset();
					end else if (kind == 1) begin
						runSpeed(col[0], col[1], col[2], col[3], col[6], col[7]);
					end else if (kind == 2) begin
						runTurret(col[0], col[1], col[2], col[3], col[4], col[5], col[6],
							col[7], col[8], col[9]);
					end else begin
						$display("unknown step kind %0d in the stimulus file", kind);
						stepFailed = 1'b1;
					end
					if (stepFailed) begin
						testsFailed++;
					end
					$display("test %0d %s: %s", testsRun, stepName(kind),
						stepFailed ? "failed" : "passed");
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, passed %0d, failed %0d", testsRun,
			testsRun - testsFailed, testsFailed);
		if (testsFailed == 0 && testsRun > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
